// ==== trap_pkg.sv ====
// --------------------------------------------------
// shared constants for the machine-mode trap logic:
// data width, CSR addresses, SYSTEM instruction
// words, mcause codes and mstatus bit positions.
// imported by wildcard in each module header
// --------------------------------------------------
package trap_pkg;

    localparam int xlen_c = 32;                 // data and address width

    typedef logic [11:0] csr_addr_t;

    // machine CSR addresses
    localparam csr_addr_t csr_mstatus_c = 12'h300;
    localparam csr_addr_t csr_mtvec_c   = 12'h305;
    localparam csr_addr_t csr_mepc_c    = 12'h341;
    localparam csr_addr_t csr_mcause_c  = 12'h342;

    // SYSTEM opcode words seen at write-back
    localparam logic [xlen_c-1:0] inst_ecall_c  = 32'h0000_0073;
    localparam logic [xlen_c-1:0] inst_ebreak_c = 32'h0010_0073;
    localparam logic [xlen_c-1:0] inst_mret_c   = 32'h3020_0073;

    // synchronous causes
    localparam logic [xlen_c-1:0] cause_ecall_c  = 32'd11;
    localparam logic [xlen_c-1:0] cause_ebreak_c = 32'd3;

    // interrupt causes, bit 31 marks an interrupt
    localparam logic [xlen_c-1:0] cause_irq_sw_c  = 32'h8000_0003;
    localparam logic [xlen_c-1:0] cause_irq_tmr_c = 32'h8000_0007;
    localparam logic [xlen_c-1:0] cause_irq_ext_c = 32'h8000_000b;

    // mstatus bit positions
    localparam int mstatus_mie_c  = 3;
    localparam int mstatus_mpie_c = 7;

    // irq_i lines: 0 software, 1 timer, 2 external
    localparam int irq_w_c = 3;

endpackage

// ==== trap_ctrl.sv ====
// --------------------------------------------------
// machine-mode trap controller. watches write-back
// for ECALL, EBREAK and MRET, takes the synchronized
// interrupt lines when MIE is set, writes mepc,
// mstatus and mcause through the shared CSR port and
// then redirects fetch to mtvec (or mepc on MRET)
// --------------------------------------------------
`timescale 1ns/10ps

module trap_ctrl import trap_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [irq_w_c-1:0] irq_i,
    input  logic [xlen_c-1:0] wb_inst_i,
    input  logic [xlen_c-1:0] wb_inst_addr_i,
    input  logic [xlen_c-1:0] pc_addr_i,
    input  logic [xlen_c-1:0] de_addr_i,
    input  logic              de_valid_i,
    input  logic [xlen_c-1:0] ex_addr_i,
    input  logic              ex_valid_i,
    input  logic [xlen_c-1:0] as_addr_i,
    input  logic              as_valid_i,
    input  logic [xlen_c-1:0] mtvec_i,
    input  logic [xlen_c-1:0] mepc_i,
    input  logic [xlen_c-1:0] mstatus_i,
    output logic              trap_we_o,
    output csr_addr_t         trap_waddr_o,
    output logic [xlen_c-1:0] trap_wdata_o,
    output logic              hold_o,
    output logic              redirect_valid_o,
    output logic [xlen_c-1:0] redirect_addr_o
);

    // one-hot sequencer states
    localparam logic [4:0] st_idle_c    = 5'b00001;
    localparam logic [4:0] st_mepc_c    = 5'b00010;
    localparam logic [4:0] st_mstatus_c = 5'b00100;
    localparam logic [4:0] st_mcause_c  = 5'b01000;
    localparam logic [4:0] st_mret_c    = 5'b10000;

    logic [4:0]         state_q;
    logic [irq_w_c-1:0] irq_meta_q;
    logic [irq_w_c-1:0] irq_sync_q;
    logic               is_idle;
    logic               is_exc;
    logic               is_mret;
    logic               irq_take;
    logic               trap_cond;
    logic [xlen_c-1:0]  cause_nxt;
    logic [xlen_c-1:0]  pc_nxt;
    logic [xlen_c-1:0]  save_pc_q;
    logic [xlen_c-1:0]  cause_q;
    logic [xlen_c-1:0]  mstatus_entry;
    logic [xlen_c-1:0]  mstatus_ret;

    // --------------------------------------------------
    // interrupt synchronizer
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_meta_q <= '0;
            irq_sync_q <= '0;
        end else begin
            irq_meta_q <= irq_i;
            irq_sync_q <= irq_meta_q;
        end
    end

    // --------------------------------------------------
    // trap decision
    // --------------------------------------------------
    assign is_idle   = (state_q == st_idle_c);
    assign is_exc    = (wb_inst_i == inst_ecall_c) || (wb_inst_i == inst_ebreak_c);
    assign is_mret   = (wb_inst_i == inst_mret_c);
    assign irq_take  = (|irq_sync_q) && mstatus_i[mstatus_mie_c];
    assign trap_cond = is_exc || irq_take || is_mret;
    assign hold_o    = !is_idle || trap_cond;

    always_comb begin
        if (is_exc) begin
            cause_nxt = (wb_inst_i == inst_ecall_c) ? cause_ecall_c : cause_ebreak_c;
            pc_nxt    = wb_inst_addr_i;
        end else begin
            // external beats software beats timer
            if (irq_sync_q[2])      cause_nxt = cause_irq_ext_c;
            else if (irq_sync_q[0]) cause_nxt = cause_irq_sw_c;
            else                    cause_nxt = cause_irq_tmr_c;
            // resume at the oldest instruction still in flight
            if (as_valid_i)         pc_nxt = as_addr_i;
            else if (ex_valid_i)    pc_nxt = ex_addr_i;
            else if (de_valid_i)    pc_nxt = de_addr_i;
            else                    pc_nxt = pc_addr_i;
        end
    end

    // mstatus images for entry and return
    always_comb begin
        mstatus_entry                 = mstatus_i;
        mstatus_entry[mstatus_mpie_c] = mstatus_i[mstatus_mie_c];
        mstatus_entry[mstatus_mie_c]  = 1'b0;
        mstatus_ret                   = mstatus_i;
        mstatus_ret[mstatus_mie_c]    = mstatus_i[mstatus_mpie_c];
        mstatus_ret[mstatus_mpie_c]   = 1'b1;
    end

    // --------------------------------------------------
    // sequencer
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle_c;
        end else begin
            case (state_q)
                st_idle_c: begin
                    if (is_exc || irq_take) state_q <= st_mepc_c;
                    else if (is_mret)       state_q <= st_mret_c;
                end
                st_mepc_c:    state_q <= st_mstatus_c;
                st_mstatus_c: state_q <= st_mcause_c;
                default:      state_q <= st_idle_c;  // mcause, mret
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (is_idle && (is_exc || irq_take)) begin
            save_pc_q <= pc_nxt;
            cause_q   <= cause_nxt;
        end
    end

    // write strobe and redirect pulse, one cycle each
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trap_we_o        <= 1'b0;
            redirect_valid_o <= 1'b0;
        end else begin
            trap_we_o        <= !is_idle;
            redirect_valid_o <= (state_q == st_mcause_c) || (state_q == st_mret_c);
        end
    end

    always_ff @(posedge clk) begin
        trap_waddr_o    <= csr_mstatus_c;
        trap_wdata_o    <= mstatus_entry;
        redirect_addr_o <= mtvec_i;
        case (state_q)
            st_mepc_c: begin
                trap_waddr_o <= csr_mepc_c;
                trap_wdata_o <= save_pc_q;
            end
            st_mcause_c: begin
                trap_waddr_o <= csr_mcause_c;
                trap_wdata_o <= cause_q;
            end
            st_mret_c: begin
                trap_wdata_o    <= mstatus_ret;
                redirect_addr_o <= mepc_i;
            end
            default: ;
        endcase
    end

endmodule

// ==== csr_write_arb.sv ====
// --------------------------------------------------
// fixed-priority arbiter for the single CSR write
// port. trap writes always win; the pipeline request
// is valid/ready and waits while a trap write runs.
// the accepted write goes out on the same edge
// --------------------------------------------------
`timescale 1ns/10ps

module csr_write_arb import trap_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              trap_we_i,
    input  csr_addr_t         trap_waddr_i,
    input  logic [xlen_c-1:0] trap_wdata_i,
    input  logic              req_valid_i,
    input  csr_addr_t         req_addr_i,
    input  logic [xlen_c-1:0] req_data_i,
    output logic              req_ready_o,
    output logic              we_o,
    output csr_addr_t         waddr_o,
    output logic [xlen_c-1:0] wdata_o
);

    logic              stolen_q;      // trap took the port from a waiting request
    csr_addr_t         held_addr_q;
    logic [xlen_c-1:0] held_data_q;
    logic              pipe_we;

    assign req_ready_o = !trap_we_i;
    assign pipe_we     = req_valid_i && !trap_we_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stolen_q <= 1'b0;
        end else if (trap_we_i && req_valid_i) begin
            stolen_q <= 1'b1;
        end else if (pipe_we) begin
            stolen_q <= 1'b0;                // retired once
        end
    end

    // keep the copy of the request that lost the port
    always_ff @(posedge clk) begin
        if (trap_we_i && req_valid_i && !stolen_q) begin
            held_addr_q <= req_addr_i;
            held_data_q <= req_data_i;
        end
    end

    assign we_o    = trap_we_i || pipe_we;
    assign waddr_o = trap_we_i ? trap_waddr_i : (stolen_q ? held_addr_q : req_addr_i);
    assign wdata_o = trap_we_i ? trap_wdata_i : (stolen_q ? held_data_q : req_data_i);

endmodule

// ==== csr_file.sv ====
// --------------------------------------------------
// machine CSRs mtvec, mepc, mcause and mstatus.
// one write port fed by the arbiter, one read port
// decoded combinationally; mtvec, mepc and mstatus
// also go straight to the trap controller
// --------------------------------------------------
`timescale 1ns/10ps

module csr_file import trap_pkg::*; #(
    parameter logic [xlen_c-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we_i,
    input  csr_addr_t         waddr_i,
    input  logic [xlen_c-1:0] wdata_i,
    input  csr_addr_t         raddr_i,
    output logic [xlen_c-1:0] rdata_o,
    output logic [xlen_c-1:0] mtvec_o,
    output logic [xlen_c-1:0] mepc_o,
    output logic [xlen_c-1:0] mstatus_o
);

    logic [xlen_c-1:0] mtvec_q;
    logic [xlen_c-1:0] mepc_q;
    logic [xlen_c-1:0] mcause_q;
    logic [xlen_c-1:0] mstatus_q;

    // --------------------------------------------------
    // write port
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q   <= MTVEC_RESET;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mstatus_q <= '0;
        end else if (we_i) begin
            case (waddr_i)
                // direct mode only, base stays word aligned
                csr_mtvec_c:   mtvec_q   <= {wdata_i[xlen_c-1:2], 2'b00};
                csr_mepc_c:    mepc_q    <= {wdata_i[xlen_c-1:2], 2'b00};
                csr_mcause_c:  mcause_q  <= wdata_i;
                csr_mstatus_c: mstatus_q <= wdata_i;
                default: ;                          // unknown address, dropped
            endcase
        end
    end

    // --------------------------------------------------
    // read port
    // --------------------------------------------------
    always_comb begin
        case (raddr_i)
            csr_mtvec_c:   rdata_o = mtvec_q;
            csr_mepc_c:    rdata_o = mepc_q;
            csr_mcause_c:  rdata_o = mcause_q;
            csr_mstatus_c: rdata_o = mstatus_q;
            default:       rdata_o = '0;
        endcase
    end

    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;
    assign mstatus_o = mstatus_q;

endmodule

// ==== trap_top.sv ====
// --------------------------------------------------
// trap subsystem top: trap controller and pipeline
// CSR writes share the CSR file write port through
// the arbiter. MTVEC_RESET sets the handler base
// --------------------------------------------------
`timescale 1ns/10ps

module trap_top import trap_pkg::*; #(
    parameter logic [xlen_c-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [irq_w_c-1:0] irq_i,
    input  logic [xlen_c-1:0]  wb_inst_i,
    input  logic [xlen_c-1:0]  wb_inst_addr_i,
    input  logic [xlen_c-1:0]  pc_addr_i,
    input  logic [xlen_c-1:0]  de_addr_i,
    input  logic               de_valid_i,
    input  logic [xlen_c-1:0]  ex_addr_i,
    input  logic               ex_valid_i,
    input  logic [xlen_c-1:0]  as_addr_i,
    input  logic               as_valid_i,
    input  logic               csr_wr_valid_i,
    output logic               csr_wr_ready_o,
    input  csr_addr_t          csr_wr_addr_i,
    input  logic [xlen_c-1:0]  csr_wr_data_i,
    input  csr_addr_t          csr_rd_addr_i,
    output logic [xlen_c-1:0]  csr_rd_data_o,
    output logic               hold_o,
    output logic               redirect_valid_o,
    output logic [xlen_c-1:0]  redirect_addr_o
);

    // trap write channel
    logic              trap_we;
    csr_addr_t         trap_waddr;
    logic [xlen_c-1:0] trap_wdata;
    // arbitrated port into the CSR file
    logic              csr_we;
    csr_addr_t         csr_waddr;
    logic [xlen_c-1:0] csr_wdata;
    logic [xlen_c-1:0] mtvec;
    logic [xlen_c-1:0] mepc;
    logic [xlen_c-1:0] mstatus;

    trap_ctrl u_trap_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .irq_i            (irq_i),
        .wb_inst_i        (wb_inst_i),
        .wb_inst_addr_i   (wb_inst_addr_i),
        .pc_addr_i        (pc_addr_i),
        .de_addr_i        (de_addr_i),
        .de_valid_i       (de_valid_i),
        .ex_addr_i        (ex_addr_i),
        .ex_valid_i       (ex_valid_i),
        .as_addr_i        (as_addr_i),
        .as_valid_i       (as_valid_i),
        .mtvec_i          (mtvec),
        .mepc_i           (mepc),
        .mstatus_i        (mstatus),
        .trap_we_o        (trap_we),
        .trap_waddr_o     (trap_waddr),
        .trap_wdata_o     (trap_wdata),
        .hold_o           (hold_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_addr_o  (redirect_addr_o)
    );

    csr_write_arb u_csr_write_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .trap_we_i    (trap_we),
        .trap_waddr_i (trap_waddr),
        .trap_wdata_i (trap_wdata),
        .req_valid_i  (csr_wr_valid_i),
        .req_addr_i   (csr_wr_addr_i),
        .req_data_i   (csr_wr_data_i),
        .req_ready_o  (csr_wr_ready_o),
        .we_o         (csr_we),
        .waddr_o      (csr_waddr),
        .wdata_o      (csr_wdata)
    );

    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .we_i      (csr_we),
        .waddr_i   (csr_waddr),
        .wdata_i   (csr_wdata),
        .raddr_i   (csr_rd_addr_i),
        .rdata_o   (csr_rd_data_o),
        .mtvec_o   (mtvec),
        .mepc_o    (mepc),
        .mstatus_o (mstatus)
    );

endmodule

// ==== tb_trap_top.sv ====
// --------------------------------------------------
// self-checking testbench for the trap subsystem.
// directed steps cover exceptions, interrupts, MRET
// and CSR port arbitration; clocked monitors compare
// hold, ready and redirect against a per-cycle model
// --------------------------------------------------
`timescale 1ns/10ps

module tb_trap_top import trap_pkg::*; ();

    localparam logic [xlen_c-1:0] mtvec_reset_c = 32'h0000_0240;
    localparam logic [xlen_c-1:0] inst_nop_c    = 32'h0000_0013;
    localparam int n_steps_c = 12;
    localparam int cyc_max_c = 1024;

    logic               clk = 1'b0;
    logic               rst_n;
    logic [irq_w_c-1:0] irq_i;
    logic [xlen_c-1:0]  wb_inst_i;
    logic [xlen_c-1:0]  wb_inst_addr_i;
    logic [xlen_c-1:0]  pc_addr_i;
    logic [xlen_c-1:0]  de_addr_i;
    logic [xlen_c-1:0]  ex_addr_i;
    logic [xlen_c-1:0]  as_addr_i;
    logic               de_valid_i;
    logic               ex_valid_i;
    logic               as_valid_i;
    logic               csr_wr_valid_i;
    logic               csr_wr_ready_o;
    csr_addr_t          csr_wr_addr_i;
    logic [xlen_c-1:0]  csr_wr_data_i;
    csr_addr_t          csr_rd_addr_i;
    logic [xlen_c-1:0]  csr_rd_data_o;
    logic               hold_o;
    logic               redirect_valid_o;
    logic [xlen_c-1:0]  redirect_addr_o;

    integer seed = 32'hbe6b_7ceb;
    int     cyc = 0;
    int     errors = 0;
    int     checks = 0;
    int     hs_cnt = 0;         // accepted pipeline writes
    int     trap_wr_cnt = 0;    // trap writes the model expects
    int     port_wr_cnt = 0;    // writes seen on the CSR file port
    logic   mon_en = 1'b0;

    // expected per-cycle behaviour filled in before each trap
    bit                exp_hold [cyc_max_c];
    bit                exp_twr  [cyc_max_c];
    bit                exp_rv   [cyc_max_c];
    logic [xlen_c-1:0] exp_ra   [cyc_max_c];

    // CSR model
    logic [xlen_c-1:0] m_mtvec;
    logic [xlen_c-1:0] m_mepc;
    logic [xlen_c-1:0] m_mcause;
    logic [xlen_c-1:0] m_mstatus;

    trap_top #(.MTVEC_RESET(mtvec_reset_c)) DUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("error %0t: %s", $time, msg);
        end
    endtask

    // --------------------------------------------------
    // cycle monitors
    // --------------------------------------------------
    always @(posedge clk) begin
        if (mon_en) begin
            if (DUT.csr_we) port_wr_cnt++;
            check(hold_o == exp_hold[cyc], $sformatf("hold_o %0b, expected %0b",
                  hold_o, exp_hold[cyc]));
            check(csr_wr_ready_o == !exp_twr[cyc], $sformatf("csr_wr_ready_o %0b, expected %0b",
                  csr_wr_ready_o, !exp_twr[cyc]));
            check(redirect_valid_o == exp_rv[cyc], $sformatf("redirect_valid_o %0b, expected %0b",
                  redirect_valid_o, exp_rv[cyc]));
            if (exp_rv[cyc])
                check(redirect_addr_o == exp_ra[cyc], $sformatf("redirect to %h, expected %h",
                      redirect_addr_o, exp_ra[cyc]));
        end
    end

    // start is the first cycle with the trap condition present
    task automatic expect_trap(input int start, input bit mret, input logic [xlen_c-1:0] target);
        int last;
        int i;
        last = mret ? start + 2 : start + 4;
        for (i = start; i < last; i++) begin
            exp_hold[i] = 1'b1;
        end
        for (i = start + 2; i <= last; i++) begin
            exp_twr[i] = 1'b1;                  // mepc, mstatus, mcause
        end
        exp_rv[last] = 1'b1;
        exp_ra[last] = target;
        trap_wr_cnt += last - start - 1;
    endtask

    function automatic void model_write(input csr_addr_t a, input logic [xlen_c-1:0] d);
        case (a)
            csr_mtvec_c:   m_mtvec   = {d[xlen_c-1:2], 2'b00};
            csr_mepc_c:    m_mepc    = {d[xlen_c-1:2], 2'b00};
            csr_mcause_c:  m_mcause  = d;
            csr_mstatus_c: m_mstatus = d;
            default: ;
        endcase
    endfunction

    function automatic void model_entry(input logic [xlen_c-1:0] pc, input logic [xlen_c-1:0] c);
        m_mepc                    = {pc[xlen_c-1:2], 2'b00};
        m_mcause                  = c;
        m_mstatus[mstatus_mpie_c] = m_mstatus[mstatus_mie_c];
        m_mstatus[mstatus_mie_c]  = 1'b0;
    endfunction

    task automatic csr_read(input csr_addr_t a, output logic [xlen_c-1:0] d);
        csr_rd_addr_i <= a;
        @(posedge clk);
        d = csr_rd_data_o;
    endtask

    task automatic check_csrs();
        logic [xlen_c-1:0] d;
        csr_read(csr_mtvec_c, d);
        check(d == m_mtvec, $sformatf("mtvec %h, expected %h", d, m_mtvec));
        csr_read(csr_mepc_c, d);
        check(d == m_mepc, $sformatf("mepc %h, expected %h", d, m_mepc));
        csr_read(csr_mcause_c, d);
        check(d == m_mcause, $sformatf("mcause %h, expected %h", d, m_mcause));
        csr_read(csr_mstatus_c, d);
        check(d == m_mstatus, $sformatf("mstatus %h, expected %h", d, m_mstatus));
        csr_read(12'h7c0, d);                   // unmapped address
        check(d == '0, $sformatf("unmapped CSR read %h, expected 0", d));
    endtask

    task automatic csr_write(input csr_addr_t a, input logic [xlen_c-1:0] d);
        int n;
        n = 0;
        csr_wr_valid_i <= 1'b1;
        csr_wr_addr_i  <= a;
        csr_wr_data_i  <= d;
        do begin
            @(posedge clk);
            n++;
        end while (!csr_wr_ready_o && n < 20);
        check(csr_wr_ready_o, "pipeline CSR write was never accepted");
        csr_wr_valid_i <= 1'b0;
        if (csr_wr_ready_o) begin
            hs_cnt++;
            model_write(a, d);
        end
    endtask

    task automatic wait_redirect(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!redirect_valid_o && n < limit);
        check(redirect_valid_o, "fetch redirect never arrived");
    endtask

    // --------------------------------------------------
    // directed steps
    // --------------------------------------------------
    task automatic take_exception(input logic [xlen_c-1:0] inst);
        logic [xlen_c-1:0] pc;
        pc = $random(seed);
        wb_inst_i      <= inst;
        wb_inst_addr_i <= pc;
        expect_trap(cyc + 1, 1'b0, m_mtvec);
        @(posedge clk);
        wb_inst_i <= inst_nop_c;                // one cycle at write-back
        wait_redirect(6);
        model_entry(pc, (inst == inst_ecall_c) ? cause_ecall_c : cause_ebreak_c);
        check_csrs();
    endtask

    // stage_v is {access, execute, decode}
    task automatic take_irq(input logic [irq_w_c-1:0] lines, input logic [2:0] stage_v);
        logic [xlen_c-1:0] pc;
        logic [xlen_c-1:0] de;
        logic [xlen_c-1:0] ex;
        logic [xlen_c-1:0] as;
        logic [xlen_c-1:0] exp_pc;
        logic [xlen_c-1:0] cause;
        bit                taken;
        pc = $random(seed);
        de = $random(seed);
        ex = $random(seed);
        as = $random(seed);
        if (stage_v[2])      exp_pc = as;
        else if (stage_v[1]) exp_pc = ex;
        else if (stage_v[0]) exp_pc = de;
        else                 exp_pc = pc;
        if (lines[2])        cause = cause_irq_ext_c;
        else if (lines[0])   cause = cause_irq_sw_c;
        else                 cause = cause_irq_tmr_c;
        taken = m_mstatus[mstatus_mie_c];
        pc_addr_i  <= pc;
        de_addr_i  <= de;
        ex_addr_i  <= ex;
        as_addr_i  <= as;
        as_valid_i <= stage_v[2];
        ex_valid_i <= stage_v[1];
        de_valid_i <= stage_v[0];
        irq_i      <= lines;
        if (taken) begin
            expect_trap(cyc + 3, 1'b0, m_mtvec); // two synchronizer edges first
            wait_redirect(8);
            model_entry(exp_pc, cause);
        end else begin
            repeat (8) @(posedge clk);
        end
        irq_i <= '0;
        repeat (3) @(posedge clk);              // synchronizer drains
        check_csrs();
    endtask

    task automatic do_mret();
        wb_inst_i <= inst_mret_c;
        expect_trap(cyc + 1, 1'b1, m_mepc);
        @(posedge clk);
        wb_inst_i <= inst_nop_c;
        wait_redirect(4);
        m_mstatus[mstatus_mie_c]  = m_mstatus[mstatus_mpie_c];
        m_mstatus[mstatus_mpie_c] = 1'b1;
        check_csrs();
    endtask

    // pipeline write raised on the mepc write cycle waits out the trap
    task automatic arb_stalled_write();
        logic [xlen_c-1:0] pc;
        logic [xlen_c-1:0] d;
        pc = $random(seed);
        d  = $random(seed);
        wb_inst_i      <= inst_ebreak_c;
        wb_inst_addr_i <= pc;
        expect_trap(cyc + 1, 1'b0, m_mtvec);
        @(posedge clk);
        wb_inst_i <= inst_nop_c;
        @(posedge clk);
        model_entry(pc, cause_ebreak_c);        // trap writes land first
        csr_write(csr_mstatus_c, d);
        check_csrs();
    endtask

    // pipeline mepc write accepted before the trap overwrites mepc
    task automatic arb_superseded_write();
        logic [xlen_c-1:0] pc;
        pc = $random(seed);
        wb_inst_i      <= inst_ecall_c;
        wb_inst_addr_i <= pc;
        expect_trap(cyc + 1, 1'b0, m_mtvec);
        csr_write(csr_mepc_c, $random(seed));
        wb_inst_i <= inst_nop_c;
        wait_redirect(6);
        model_entry(pc, cause_ecall_c);
        check_csrs();
    endtask

    initial begin
        rst_n          = 1'b0;
        irq_i          = '0;
        wb_inst_i      = inst_nop_c;
        wb_inst_addr_i = '0;
        pc_addr_i      = '0;
        de_addr_i      = '0;
        ex_addr_i      = '0;
        as_addr_i      = '0;
        de_valid_i     = 1'b0;
        ex_valid_i     = 1'b0;
        as_valid_i     = 1'b0;
        csr_wr_valid_i = 1'b0;
        csr_wr_addr_i  = '0;
        csr_wr_data_i  = '0;
        csr_rd_addr_i  = '0;
        m_mtvec        = mtvec_reset_c;
        m_mepc         = '0;
        m_mcause       = '0;
        m_mstatus      = '0;
        repeat (3) @(posedge clk);
        rst_n  <= 1'b1;
        mon_en <= 1'b1;
        check(!hold_o && !redirect_valid_o && csr_wr_ready_o, "outputs wrong in reset");
        check_csrs();
        csr_write(csr_mstatus_c, 32'h0000_0008);    // MIE on
        take_exception(inst_ecall_c);
        take_exception(inst_ebreak_c);
        csr_write(csr_mtvec_c, $random(seed));
        csr_write(csr_mstatus_c, 32'h0000_0008);
        take_irq(3'b111, 3'b111);
        csr_write(csr_mstatus_c, 32'h0000_0008);
        take_irq(3'b011, 3'b010);
        csr_write(csr_mstatus_c, 32'h0000_0008);
        take_irq(3'b010, 3'b001);
        csr_write(csr_mstatus_c, 32'h0000_0008);
        take_irq(3'b100, 3'b000);
        take_irq(3'b001, 3'b000);                   // MIE now clear so the line is ignored
        csr_write(csr_mepc_c, $random(seed));
        csr_write(csr_mstatus_c, 32'h0000_0080);    // MPIE set with MIE clear
        do_mret();
        arb_stalled_write();
        arb_superseded_write();
        repeat (2) @(posedge clk);
        @(negedge clk);                             // last monitor checks are done
        check(port_wr_cnt == trap_wr_cnt + hs_cnt,
              $sformatf("%0d port writes, expected %0d", port_wr_cnt, trap_wr_cnt + hs_cnt));
        $display("checks %0d, errors %0d, pipeline writes %0d", checks, errors, hs_cnt);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog allows 40 cycles per step
    initial begin
        repeat (n_steps_c * 40) @(posedge clk);
        $display("watchdog expired after %0d cycles, test did not finish", n_steps_c * 40);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
trap_pkg.sv
trap_ctrl.sv
csr_write_arb.sv
csr_file.sv
trap_top.sv
tb_trap_top.sv
